//--- tb.f
common/hpsdr_pkg.sv
verilog/ds_sample_packer.sv
verilog/ds_cmd_bank.sv
ds_unpacker/ds_unpacker.sv
verilog/hpsdr_downstream_top.sv
dv/tb_clock.sv
dv/hpsdr_downstream_checker.sv
dv/hpsdr_downstream_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; success only when the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module hpsdr_downstream_tb -f tb.f &&
./obj_dir/Vhpsdr_downstream_tb | tee /dev/stderr | grep -qx "sim passed" ||
{ echo "simulation run did not pass" >&2; exit 1; }

//--- dv/hpsdr_downstream_tb.sv
// Drives whole packets with eth.valid held high; outputs are sampled 1 ns after each falling edge
`timescale 1ns/100ps

module hpsdr_downstream_tb;

  import hpsdr_pkg::*;

  logic        clk;
  logic        reset;
  eth_rx_t     eth;
  logic        watchdog_up;
  logic        asmi_erase_ack;
  ds_byte_t    asmi;
  logic [13:0] asmi_cnt;
  logic        asmi_erase;
  logic        discovery;
  logic        run;
  logic        wide_spectrum;
  logic        ptt;
  sample_t     lr_sample;
  sample_t     iq_sample;
  radio_cfg_t  cfg;
  logic [31:0] tx_freq;
  cmd_t        last_cmd;

  logic [7:0]  pkt[$];
  logic [31:0] exp_lr[$];
  logic [31:0] exp_iq[$];
  logic [39:0] exp_cmd[$];
  logic [7:0]  exp_asmi[$];

  int          seed;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_bad;
  string       test_name;
  logic        armed;
  logic        prev_toggle;
  logic [31:0] seq_no;
  int          lr_seen;
  int          iq_seen;
  int          disc_seen;
  int          asmi_seen;
  int          asmi_last_seen;

  tb_clock clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  hpsdr_downstream_top dut (
    .clk            (clk),
    .reset          (reset),
    .eth            (eth),
    .watchdog_up    (watchdog_up),
    .asmi           (asmi),
    .asmi_cnt       (asmi_cnt),
    .asmi_erase     (asmi_erase),
    .asmi_erase_ack (asmi_erase_ack),
    .discovery      (discovery),
    .run            (run),
    .wide_spectrum  (wide_spectrum),
    .ptt            (ptt),
    .lr_sample      (lr_sample),
    .iq_sample      (iq_sample),
    .cfg            (cfg),
    .tx_freq        (tx_freq),
    .last_cmd       (last_cmd)
  );

  bind ds_unpacker hpsdr_downstream_checker unpacker_checks (
    .clk            (clk),
    .reset          (reset),
    .eth            (eth),
    .asmi_erase_ack (asmi_erase_ack),
    .wdog_expired   (wdog_expired),
    .discovery      (discovery),
    .asmi_erase     (asmi_erase),
    .payload        (payload),
    .cmd            (cmd)
  );

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("At %0d ns: %s", $time, what);
  endtask

  // Expected words and command from one subframe starting at pkt[base]
  function automatic void model_subframe(input int base);
    logic [7:0] ctrl;
    int         k;
    int         s;
    ctrl = pkt[base + 3];
    exp_cmd.push_back({ctrl[7], ctrl[6:1], ctrl[0], pkt[base + 4], pkt[base + 5],
                       pkt[base + 6], pkt[base + 7]});
    for (s = 0; s < SAMPLES_PER_SUBFRAME; s++) begin
      k = base + 8 + 8 * s;
      exp_lr.push_back({pkt[k], pkt[k + 1], pkt[k + 2], pkt[k + 3]});
      if (ctrl[0]) exp_iq.push_back({pkt[k + 4], pkt[k + 5], pkt[k + 6], pkt[k + 7]});
    end
  endfunction

  task automatic start_packet(input logic [7:0] kind);
    pkt.delete();
    pkt.push_back(PREAMBLE0);
    pkt.push_back(PREAMBLE1);
    pkt.push_back(kind);
  endtask

  task automatic start_frame();
    int i;
    start_packet(PKT_DATA);
    pkt.push_back(EP_DS_DATA);
    for (i = 3; i >= 0; i--) pkt.push_back(seq_no[8 * i +: 8]);
    seq_no++;
  endtask

  task automatic add_subframe(input logic [5:0] addr, input logic ptt_bit);
    int          base;
    int          i;
    logic [31:0] word;
    logic        rq;
    base = pkt.size();
    word = $random(seed);
    rq = 1'($random(seed));
    repeat (3) pkt.push_back(SYNC_BYTE);
    pkt.push_back({rq, addr, ptt_bit});
    for (i = 3; i >= 0; i--) pkt.push_back(word[8 * i +: 8]);
    for (i = 0; i < 8 * SAMPLES_PER_SUBFRAME; i++) pkt.push_back(8'($random(seed)));
    model_subframe(base);
  endtask

  task automatic drive_bytes(input logic [15:0] port, input logic bcast);
    int i;
    for (i = 0; i < pkt.size(); i++) begin
      @(negedge clk);
      eth.port = port;
      eth.broadcast = bcast;
      eth.valid = 1'b1;
      eth.data = pkt[i];
    end
  endtask

  task automatic end_packet();
    @(negedge clk);
    eth.valid = 1'b0;
    eth.broadcast = 1'b0;
    eth.port = HPSDR_PORT;
    pkt.delete();
  endtask

  task automatic send_packet(input logic [15:0] port, input logic bcast);
    drive_bytes(port, bcast);
    end_packet();
  endtask

  task automatic send_runstop(input logic [15:0] port, input logic [7:0] mode);
    start_packet(PKT_RUNSTOP);
    pkt.push_back(mode);
    send_packet(port, 1'b0);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic tick_watchdog(input int n);
    repeat (n) begin
      @(negedge clk);
      watchdog_up = 1'b1;
    end
    @(negedge clk);
    watchdog_up = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_lr.size() + exp_iq.size() + exp_cmd.size() + exp_asmi.size()) != 0 &&
           n < 32) begin
      @(negedge clk);
      n++;
    end
    if ((exp_lr.size() + exp_iq.size() + exp_cmd.size() + exp_asmi.size()) != 0) begin
      report_failure("timed out waiting for expected samples or commands");
      exp_lr.delete();
      exp_iq.delete();
      exp_cmd.delete();
      exp_asmi.delete();
    end
    idle(2);
  endtask

  task automatic wait_run_low(input int limit);
    int n;
    n = 0;
    while (run !== 1'b0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (run !== 1'b0) report_failure("timed out waiting for run to clear");
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", test_name, errors - test_errors);
    end
  endtask

  // Compare process
  initial begin : compare_outputs
    logic [31:0] w;
    logic [39:0] c;
    logic [7:0]  b;
    logic [31:0] freq_want;
    logic [31:0] cfg_want;
    logic        freq_known;
    freq_want = '0;
    cfg_want = '0;
    freq_known = 1'b0;
    forever begin
      @(negedge clk);
      #1;
      if (!armed) begin
        prev_toggle = last_cmd.toggle;
      end else begin
        if (lr_sample.valid) begin
          lr_seen++;
          if (exp_lr.size() == 0) begin
            report_failure("audio sample arrived with none expected");
          end else begin
            w = exp_lr.pop_front();
            check("lr_sample", {lr_sample.hi, lr_sample.lo}, w);
          end
        end
        if (iq_sample.valid) begin
          iq_seen++;
          if (exp_iq.size() == 0) begin
            report_failure("IQ sample arrived with none expected");
          end else begin
            w = exp_iq.pop_front();
            check("iq_sample", {iq_sample.hi, iq_sample.lo}, w);
          end
        end
        if (last_cmd.toggle !== prev_toggle) begin
          prev_toggle = last_cmd.toggle;
          if (exp_cmd.size() == 0) begin
            report_failure("command registered with none expected");
          end else begin
            c = exp_cmd.pop_front();
            check("last_cmd.resprqst", 32'(last_cmd.resprqst), 32'(c[39]));
            check("last_cmd.addr", 32'(last_cmd.addr), 32'(c[38:33]));
            check("last_cmd.ptt", 32'(last_cmd.ptt), 32'(c[32]));
            check("last_cmd.data", last_cmd.data, c[31:0]);
            check("ptt", 32'(ptt), 32'(c[32]));
            if (c[38:33] == CMD_ADDR_TX_FREQ) begin
              freq_want = c[31:0];
              freq_known = 1'b1;
            end
            if (c[38:33] == CMD_ADDR_CONFIG) cfg_want = c[31:0];
            // Other addresses must leave both registers alone
            if (freq_known) check("tx_freq", tx_freq, freq_want);
            check("cfg.speed", 32'(cfg.speed), 32'(cfg_want[25:24]));
            check("cfg.n_rx", 32'(cfg.n_rx), 32'(cfg_want[5:3]));
            check("cfg.duplex", 32'(cfg.duplex), 32'(cfg_want[2]));
          end
        end
        if (discovery) disc_seen++;
        if (asmi.asmi_valid) begin
          asmi_seen++;
          if (asmi.asmi_last) asmi_last_seen++;
          if (exp_asmi.size() == 0) begin
            report_failure("flash byte arrived with none expected");
          end else begin
            b = exp_asmi.pop_front();
            check("asmi.data", 32'(asmi.data), 32'(b));
            check("asmi.asmi_last", 32'(asmi.asmi_last), 32'(exp_asmi.size() == 0));
          end
        end else if (asmi.asmi_last) begin
          report_failure("asmi_last seen without asmi_valid");
        end
      end
    end
  end

  initial begin : main_flow
    int          n;
    int          base;
    int          i;
    logic [13:0] cnt;
    logic [7:0]  b;
    seed = 32'h8ee5_05aa;
    eth = '0;
    eth.port = HPSDR_PORT;
    watchdog_up = 1'b0;
    asmi_erase_ack = 1'b0;
    armed = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    seq_no = '0;
    lr_seen = 0;
    iq_seen = 0;
    disc_seen = 0;
    asmi_seen = 0;
    asmi_last_seen = 0;
    n = 0;
    while (reset !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (reset !== 1'b0) report_failure("reset never released");
    idle(2);
    armed = 1'b1;

    begin_test("run_stop");
    send_runstop(HPSDR_PORT, 8'h03);
    idle(2);
    check("run", 32'(run), 32'd1);
    check("wide_spectrum", 32'(wide_spectrum), 32'd1);
    send_runstop(HPSDR_PORT, 8'h00);
    idle(2);
    check("run", 32'(run), 32'd0);
    check("wide_spectrum", 32'(wide_spectrum), 32'd0);
    send_runstop(HPSDR_PORT + 16'd1, 8'h03);
    idle(2);
    check("run on wrong port", 32'(run), 32'd0);
    check("wide_spectrum on wrong port", 32'(wide_spectrum), 32'd0);
    end_test();

    begin_test("frame_ptt_off");
    base = lr_seen;
    n = iq_seen;
    start_frame();
    add_subframe(CMD_ADDR_TX_FREQ, 1'b0);
    add_subframe(CMD_ADDR_CONFIG, 1'b0);
    send_packet(HPSDR_PORT, 1'b0);
    wait_drained();
    check("audio word count", lr_seen - base, 32'd126);
    check("IQ word count", iq_seen - n, 32'd0);
    end_test();

    begin_test("frame_ptt_on");
    base = lr_seen;
    n = iq_seen;
    start_frame();
    add_subframe(CMD_ADDR_TX_FREQ, 1'b1);
    add_subframe(CMD_ADDR_CONFIG, 1'b1);
    send_packet(HPSDR_PORT, 1'b0);
    wait_drained();
    check("ptt", 32'(ptt), 32'd1);
    check("audio word count", lr_seen - base, 32'd126);
    check("IQ word count", iq_seen - n, 32'd126);
    end_test();

    begin_test("discovery");
    base = disc_seen;
    start_packet(PKT_DISCOVERY);
    pkt.push_back(8'h00);
    send_packet(HPSDR_PORT, 1'b1);
    idle(2);
    check("discovery pulses with broadcast", disc_seen - base, 32'd1);
    start_packet(PKT_DISCOVERY);
    pkt.push_back(8'h00);
    send_packet(HPSDR_PORT, 1'b0);
    idle(2);
    check("discovery pulses without broadcast", disc_seen - base, 32'd1);
    end_test();

    begin_test("flash");
    base = asmi_seen;
    n = asmi_last_seen;
    cnt = 14'($random(seed));
    start_packet(PKT_ASMI);
    pkt.push_back(ASMI_OP_PROGRAM);
    pkt.push_back(8'h00);
    pkt.push_back(8'h00);
    pkt.push_back({2'b00, cnt[13:8]});
    pkt.push_back(cnt[7:0]);
    for (i = 0; i < ASMI_BLOCK_BYTES; i++) begin
      b = 8'($random(seed));
      pkt.push_back(b);
      exp_asmi.push_back(b);
    end
    send_packet(HPSDR_PORT, 1'b0);
    wait_drained();
    check("asmi_cnt", 32'(asmi_cnt), 32'(cnt));
    check("flash strobe count", asmi_seen - base, 32'd256);
    check("flash last count", asmi_last_seen - n, 32'd1);
    // Erase waits with valid filler bytes
    start_packet(PKT_ASMI);
    pkt.push_back(ASMI_OP_ERASE);
    repeat (4) pkt.push_back(8'h00);
    drive_bytes(HPSDR_PORT, 1'b0);
    #1;
    check("asmi_erase before ack", 32'(asmi_erase), 32'd1);
    @(negedge clk);
    asmi_erase_ack = 1'b1;
    n = 0;
    while (asmi_erase !== 1'b0 && n < 16) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (asmi_erase !== 1'b0) report_failure("asmi_erase stayed high after acknowledge");
    @(negedge clk);
    asmi_erase_ack = 1'b0;
    end_packet();
    end_test();

    begin_test("watchdog");
    send_runstop(HPSDR_PORT, 8'h01);
    idle(2);
    check("run", 32'(run), 32'd1);
    tick_watchdog(1022);
    idle(2);
    check("run one tick before limit", 32'(run), 32'd1);
    tick_watchdog(1);
    wait_run_low(8);
    send_runstop(HPSDR_PORT, 8'h01);
    tick_watchdog(600);
    start_frame();
    add_subframe(6'd2, 1'b0);
    send_packet(HPSDR_PORT, 1'b0);
    wait_drained();
    tick_watchdog(600);
    idle(2);
    check("run kept by data frame", 32'(run), 32'd1);
    @(negedge clk);
    eth.unreachable = 1'b1;
    @(negedge clk);
    eth.unreachable = 1'b0;
    check("run after unreachable", 32'(run), 32'd0);
    end_test();

    $display("%0d tests, %0d with errors, %0d errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- dv/hpsdr_downstream_checker.sv
// Bound to ds_unpacker; rules are skipped while reset is high
`timescale 1ns/100ps

module hpsdr_downstream_checker (
  input logic                clk,
  input logic                reset,
  input hpsdr_pkg::eth_rx_t  eth,
  input logic                asmi_erase_ack,
  input logic                wdog_expired,
  input logic                discovery,
  input logic                asmi_erase,
  input hpsdr_pkg::ds_byte_t payload,
  input hpsdr_pkg::cmd_t     cmd
);

  assert property (@(posedge clk) disable iff (reset) payload.lr_last |-> payload.lr_valid)
    else $error("lr_last seen without lr_valid");

  // IQ strobes only while transmitting
  assert property (@(posedge clk) disable iff (reset)
    (payload.iq_valid || payload.iq_last) |-> cmd.ptt)
    else $error("IQ strobe while PTT is low");

  assert property (@(posedge clk) disable iff (reset)
    (asmi_erase && !asmi_erase_ack && eth.valid && !eth.unreachable && !wdog_expired)
    |=> asmi_erase)
    else $error("asmi_erase dropped before acknowledge");

  assert property (@(posedge clk) disable iff (reset) discovery |=> !discovery)
    else $error("discovery pulse longer than one cycle");

endmodule

//--- dv/tb_clock.sv
// Free-running 8 ns clock; reset high for the first 3 rising edges, released on a falling edge
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- verilog/hpsdr_downstream_top.sv
// Flash controller and UDP receiver sit outside; asmi carries the whole byte stream
`timescale 1ns/100ps

module hpsdr_downstream_top (
  input  logic                  clk,
  input  logic                  reset,
  input  hpsdr_pkg::eth_rx_t    eth,
  input  logic                  watchdog_up,
  output hpsdr_pkg::ds_byte_t   asmi,
  output logic [13:0]           asmi_cnt,
  output logic                  asmi_erase,
  input  logic                  asmi_erase_ack,
  output logic                  discovery,
  output logic                  run,
  output logic                  wide_spectrum,
  output logic                  ptt,
  output hpsdr_pkg::sample_t    lr_sample,
  output hpsdr_pkg::sample_t    iq_sample,
  output hpsdr_pkg::radio_cfg_t cfg,
  output logic [31:0]           tx_freq,
  output hpsdr_pkg::cmd_t       last_cmd
);

  import hpsdr_pkg::*;

  ds_byte_t payload;
  cmd_t     cmd;

  assign asmi = payload;

  ds_unpacker unpacker (
    .clk            (clk),
    .reset          (reset),
    .eth            (eth),
    .watchdog_up    (watchdog_up),
    .asmi_erase_ack (asmi_erase_ack),
    .discovery      (discovery),
    .run            (run),
    .wide_spectrum  (wide_spectrum),
    .payload        (payload),
    .cmd            (cmd),
    .asmi_cnt       (asmi_cnt),
    .asmi_erase     (asmi_erase)
  );

  // Left/right audio words
  ds_sample_packer lr_packer (
    .clk    (clk),
    .reset  (reset),
    .data   (payload.data),
    .valid  (payload.lr_valid),
    .last   (payload.lr_last),
    .sample (lr_sample)
  );

  // Transmit IQ words, strobed only under PTT
  ds_sample_packer iq_packer (
    .clk    (clk),
    .reset  (reset),
    .data   (payload.data),
    .valid  (payload.iq_valid),
    .last   (payload.iq_last),
    .sample (iq_sample)
  );

  ds_cmd_bank cmd_bank (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cmd),
    .cfg      (cfg),
    .tx_freq  (tx_freq),
    .last_cmd (last_cmd),
    .ptt      (ptt)
  );

endmodule

//--- ds_unpacker/ds_unpacker.sv
// Needs eth.valid high for a whole packet; no back-pressure, strobes follow the input byte rate
`timescale 1ns/100ps

module ds_unpacker (
  input  logic               clk,
  input  logic               reset,
  input  hpsdr_pkg::eth_rx_t eth,
  input  logic               watchdog_up,
  input  logic               asmi_erase_ack,
  output logic               discovery,
  output logic               run,
  output logic               wide_spectrum,
  output hpsdr_pkg::ds_byte_t payload,
  output hpsdr_pkg::cmd_t    cmd,
  output logic [13:0]        asmi_cnt,
  output logic               asmi_erase
);

  import hpsdr_pkg::*;

  logic [5:0]  state;
  logic [5:0]  state_next;
  logic [7:0]  push_cnt;
  logic [7:0]  push_cnt_next;
  logic        run_next;
  logic        wide_spectrum_next;
  logic        ptt_q;
  logic        ptt_next;
  logic        toggle_q;
  logic        toggle_next;
  logic        resprqst_q;
  logic        resprqst_next;
  logic [5:0]  addr_q;
  logic [5:0]  addr_next;
  logic [31:0] data_q;
  logic [31:0] data_next;
  logic [13:0] asmi_cnt_next;
  logic [9:0]  wdog_cnt;
  logic        wdog_clr;
  logic        wdog_expired;
  logic        port_ok;

  assign port_ok = (eth.port == HPSDR_PORT);
  assign wdog_expired = (wdog_cnt == WATCHDOG_LIMIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_START;
      run <= 1'b0;
      wide_spectrum <= 1'b0;
      push_cnt <= 8'h00;
      ptt_q <= 1'b0;
      toggle_q <= 1'b0;
    end else begin
      push_cnt <= push_cnt_next;
      ptt_q <= ptt_next;
      toggle_q <= toggle_next;
      if (eth.unreachable || wdog_expired) begin
        state <= ST_START;
        run <= 1'b0;
        wide_spectrum <= 1'b0;
      end else if (!eth.valid) begin
        state <= ST_START;
      end else begin
        state <= state_next;
        run <= run_next;
        wide_spectrum <= wide_spectrum_next;
      end
    end
  end

  // Command fields and flash count
  always_ff @(posedge clk) begin
    resprqst_q <= resprqst_next;
    addr_q <= addr_next;
    data_q <= data_next;
    asmi_cnt <= asmi_cnt_next;
  end

  assign cmd = '{resprqst: resprqst_q, addr: addr_q, ptt: ptt_q, data: data_q,
                 toggle: toggle_q};

  always_comb begin
    state_next = ST_START;
    run_next = run;
    wide_spectrum_next = wide_spectrum;
    push_cnt_next = push_cnt;
    ptt_next = ptt_q;
    toggle_next = toggle_q;
    resprqst_next = resprqst_q;
    addr_next = addr_q;
    data_next = data_q;
    asmi_cnt_next = asmi_cnt;

    discovery = 1'b0;
    asmi_erase = 1'b0;
    wdog_clr = 1'b0;
    payload = '0;
    payload.data = eth.data;

    case (state)
      ST_START: begin
        if (eth.data == PREAMBLE0 && port_ok) state_next = ST_PREAMBLE;
      end
      ST_PREAMBLE: begin
        if (eth.data == PREAMBLE1 && port_ok) state_next = ST_DECODE;
      end
      ST_DECODE: begin
        if (eth.data == PKT_DATA) state_next = ST_ENDPOINT;
        else if (eth.data == PKT_RUNSTOP) state_next = ST_RUNSTOP;
        else if (eth.data == PKT_DISCOVERY && eth.broadcast) state_next = ST_DISCOVERY;
        else if (eth.data == PKT_ASMI) state_next = ST_ASMI_DECODE;
      end
      ST_RUNSTOP: begin
        run_next = eth.data[0];
        wide_spectrum_next = eth.data[1];
      end
      ST_DISCOVERY: begin
        discovery = 1'b1;
      end
      ST_ASMI_DECODE: begin
        push_cnt_next = 8'h00;
        if (eth.data == ASMI_OP_PROGRAM) begin
          state_next = ST_ASMI_CNT3;
        end else if (eth.data == ASMI_OP_ERASE) begin
          asmi_erase = 1'b1;
          state_next = ST_ASMI_ERASE;
        end
      end
      // Upper count bytes exceed 14 bits and are dropped
      ST_ASMI_CNT3: state_next = ST_ASMI_CNT2;
      ST_ASMI_CNT2: state_next = ST_ASMI_CNT1;
      ST_ASMI_CNT1: begin
        asmi_cnt_next = {eth.data[5:0], asmi_cnt[7:0]};
        state_next = ST_ASMI_CNT0;
      end
      ST_ASMI_CNT0: begin
        asmi_cnt_next = {asmi_cnt[13:8], eth.data};
        state_next = ST_ASMI_PROGRAM;
      end
      ST_ASMI_PROGRAM: begin
        payload.asmi_valid = 1'b1;
        push_cnt_next = push_cnt + 8'h01;
        if (push_cnt == 8'(ASMI_BLOCK_BYTES - 1)) payload.asmi_last = 1'b1;
        else state_next = ST_ASMI_PROGRAM;
      end
      ST_ASMI_ERASE: begin
        asmi_erase = 1'b1;
        if (!asmi_erase_ack) state_next = ST_ASMI_ERASE;
      end
      ST_ENDPOINT: begin
        if (eth.data == EP_DS_DATA) state_next = ST_SEQNO3;
      end
      ST_SEQNO3: state_next = ST_SEQNO2;
      ST_SEQNO2: state_next = ST_SEQNO1;
      ST_SEQNO1: state_next = ST_SEQNO0;
      ST_SEQNO0: begin
        // Frame seen, restart watchdog
        wdog_clr = 1'b1;
        state_next = ST_SYNC2;
      end
      ST_SYNC2: begin
        push_cnt_next = 8'h00;
        if (eth.data == SYNC_BYTE) state_next = ST_SYNC1;
      end
      ST_SYNC1: begin
        push_cnt_next = 8'h00;
        if (eth.data == SYNC_BYTE) state_next = ST_SYNC0;
      end
      ST_SYNC0: begin
        push_cnt_next = 8'h00;
        if (eth.data == SYNC_BYTE) state_next = ST_CMDCTRL;
      end
      ST_CMDCTRL: begin
        resprqst_next = eth.data[7];
        addr_next = eth.data[6:1];
        ptt_next = eth.data[0];
        state_next = ST_CMDDATA3;
      end
      ST_CMDDATA3: begin
        data_next = {eth.data, data_q[23:0]};
        state_next = ST_CMDDATA2;
      end
      ST_CMDDATA2: begin
        data_next = {data_q[31:24], eth.data, data_q[15:0]};
        state_next = ST_CMDDATA1;
      end
      ST_CMDDATA1: begin
        data_next = {data_q[31:16], eth.data, data_q[7:0]};
        state_next = ST_CMDDATA0;
      end
      ST_CMDDATA0: begin
        data_next = {data_q[31:8], eth.data};
        toggle_next = ~toggle_q;
        state_next = ST_PUSHL1;
      end
      ST_PUSHL1, ST_PUSHL0, ST_PUSHR1: begin
        payload.lr_valid = 1'b1;
        state_next = state + 6'h01;
      end
      ST_PUSHR0: begin
        payload.lr_valid = 1'b1;
        payload.lr_last = 1'b1;
        push_cnt_next = push_cnt + 8'h01;
        state_next = ST_PUSHI1;
      end
      ST_PUSHI1, ST_PUSHI0, ST_PUSHQ1: begin
        payload.iq_valid = ptt_q;
        state_next = state + 6'h01;
      end
      ST_PUSHQ0: begin
        payload.iq_valid = ptt_q;
        payload.iq_last = ptt_q;
        if (push_cnt == 8'(SAMPLES_PER_SUBFRAME)) state_next = ST_SYNC2;
        else state_next = ST_PUSHL1;
      end
      default: state_next = ST_START;
    endcase
  end

  // Watchdog stops run when frames stop arriving
  always_ff @(posedge clk) begin
    if (reset || !run || wdog_clr) begin
      wdog_cnt <= 10'h000;
    end else if (watchdog_up) begin
      wdog_cnt <= wdog_cnt + 10'h001;
    end
  end

endmodule

//--- verilog/ds_cmd_bank.sv
// Acts on a toggle change of cmd; only addresses 0 and 1 are decoded, others update last_cmd only
`timescale 1ns/100ps

module ds_cmd_bank (
  input  logic                  clk,
  input  logic                  reset,
  input  hpsdr_pkg::cmd_t       cmd,
  output hpsdr_pkg::radio_cfg_t cfg,
  output logic [31:0]           tx_freq,
  output hpsdr_pkg::cmd_t       last_cmd,
  output logic                  ptt
);

  import hpsdr_pkg::*;

  logic      toggle_d;
  logic      new_cmd;
  cmd_word_u word;

  assign new_cmd = cmd.toggle ^ toggle_d;
  assign word = cmd.data;

  always_ff @(posedge clk) begin
    if (reset) begin
      toggle_d <= 1'b0;
      ptt <= 1'b0;
      cfg <= '0;
    end else begin
      toggle_d <= cmd.toggle;
      if (new_cmd) begin
        ptt <= cmd.ptt;
        if (cmd.addr == CMD_ADDR_CONFIG) cfg <= word.cfg;
      end
    end
  end

  // Frequency and raw command copy
  always_ff @(posedge clk) begin
    if (new_cmd) begin
      last_cmd <= cmd;
      if (cmd.addr == CMD_ADDR_TX_FREQ) tx_freq <= word.freq;
    end
  end

endmodule

//--- verilog/ds_sample_packer.sv
// Four bytes per word, first byte most significant; last must come with the fourth strobe
`timescale 1ns/100ps

module ds_sample_packer (
  input  logic               clk,
  input  logic               reset,
  input  logic [7:0]         data,
  input  logic               valid,
  input  logic               last,
  output hpsdr_pkg::sample_t sample
);

  logic [31:0] shift_q;
  logic        done_q;

  always_ff @(posedge clk) begin
    if (valid) begin
      shift_q <= {shift_q[23:0], data};
    end
  end

  // One-cycle pulse after the closing byte
  always_ff @(posedge clk) begin
    if (reset) begin
      done_q <= 1'b0;
    end else begin
      done_q <= valid & last;
    end
  end

  assign sample.hi = shift_q[31:16];
  assign sample.lo = shift_q[15:0];
  assign sample.valid = done_q;

endmodule

//--- common/hpsdr_pkg.sv
// Protocol-1 downstream only; endpoint 2 data frames, sequence numbers are not checked
package hpsdr_pkg;

  localparam logic [15:0] HPSDR_PORT = 16'd1024;
  localparam logic [7:0] PREAMBLE0 = 8'hef;
  localparam logic [7:0] PREAMBLE1 = 8'hfe;

  // Packet types after the preamble
  localparam logic [7:0] PKT_DATA = 8'h01;
  localparam logic [7:0] PKT_DISCOVERY = 8'h02;
  localparam logic [7:0] PKT_ASMI = 8'h03;
  localparam logic [7:0] PKT_RUNSTOP = 8'h04;

  localparam logic [7:0] EP_DS_DATA = 8'h02;
  localparam logic [7:0] ASMI_OP_PROGRAM = 8'h01;
  localparam logic [7:0] ASMI_OP_ERASE = 8'h02;
  localparam logic [7:0] SYNC_BYTE = 8'h7f;

  localparam int SAMPLES_PER_SUBFRAME = 63;
  localparam int ASMI_BLOCK_BYTES = 256;
  localparam logic [9:0] WATCHDOG_LIMIT = 10'd1023;

  localparam logic [5:0] CMD_ADDR_CONFIG = 6'd0;
  localparam logic [5:0] CMD_ADDR_TX_FREQ = 6'd1;

  // Unpacker state codes
  localparam logic [5:0] ST_START = 6'h00;
  localparam logic [5:0] ST_PREAMBLE = 6'h01;
  localparam logic [5:0] ST_DECODE = 6'h02;
  localparam logic [5:0] ST_RUNSTOP = 6'h03;
  localparam logic [5:0] ST_DISCOVERY = 6'h04;
  localparam logic [5:0] ST_ENDPOINT = 6'h05;
  localparam logic [5:0] ST_SEQNO3 = 6'h06;
  localparam logic [5:0] ST_SEQNO2 = 6'h07;
  localparam logic [5:0] ST_SEQNO1 = 6'h08;
  localparam logic [5:0] ST_SEQNO0 = 6'h09;
  localparam logic [5:0] ST_SYNC2 = 6'h10;
  localparam logic [5:0] ST_SYNC1 = 6'h11;
  localparam logic [5:0] ST_SYNC0 = 6'h12;
  localparam logic [5:0] ST_CMDCTRL = 6'h13;
  localparam logic [5:0] ST_CMDDATA3 = 6'h14;
  localparam logic [5:0] ST_CMDDATA2 = 6'h15;
  localparam logic [5:0] ST_CMDDATA1 = 6'h16;
  localparam logic [5:0] ST_CMDDATA0 = 6'h17;
  localparam logic [5:0] ST_PUSHL1 = 6'h18;
  localparam logic [5:0] ST_PUSHL0 = 6'h19;
  localparam logic [5:0] ST_PUSHR1 = 6'h1a;
  localparam logic [5:0] ST_PUSHR0 = 6'h1b;
  localparam logic [5:0] ST_PUSHI1 = 6'h1c;
  localparam logic [5:0] ST_PUSHI0 = 6'h1d;
  localparam logic [5:0] ST_PUSHQ1 = 6'h1e;
  localparam logic [5:0] ST_PUSHQ0 = 6'h1f;
  localparam logic [5:0] ST_ASMI_ERASE = 6'h20;
  localparam logic [5:0] ST_ASMI_DECODE = 6'h2a;
  localparam logic [5:0] ST_ASMI_CNT3 = 6'h2b;
  localparam logic [5:0] ST_ASMI_CNT2 = 6'h2c;
  localparam logic [5:0] ST_ASMI_CNT1 = 6'h2d;
  localparam logic [5:0] ST_ASMI_CNT0 = 6'h2e;
  localparam logic [5:0] ST_ASMI_PROGRAM = 6'h2f;

  typedef struct packed {
    logic [15:0] port;
    logic        broadcast;
    logic        valid;
    logic [7:0]  data;
    logic        unreachable;
  } eth_rx_t;

  typedef struct packed {
    logic [7:0] data;
    logic       lr_valid;
    logic       lr_last;
    logic       iq_valid;
    logic       iq_last;
    logic       asmi_valid;
    logic       asmi_last;
  } ds_byte_t;

  typedef struct packed {
    logic        resprqst;
    logic [5:0]  addr;
    logic        ptt;
    logic [31:0] data;
    logic        toggle;
  } cmd_t;

  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
    logic        valid;
  } sample_t;

  // Config word at address 0
  typedef struct packed {
    logic [5:0]  rsvd_hi;
    logic [1:0]  speed;
    logic [17:0] rsvd_mid;
    logic [2:0]  n_rx;
    logic        duplex;
    logic [1:0]  rsvd_lo;
  } radio_cfg_t;

  typedef union packed {
    logic [31:0] freq;
    radio_cfg_t  cfg;
  } cmd_word_u;

endpackage
